// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int NBITS  = 32;
    localparam int REG_RA = 31;

    // Major opcodes live in instr[31:26].
    localparam logic [5:0] OPC_RTYPE = 6'h00;
    localparam logic [5:0] OPC_J     = 6'h02;
    localparam logic [5:0] OPC_JAL   = 6'h03;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_SLTI  = 6'h0a;
    localparam logic [5:0] OPC_ANDI  = 6'h0c;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_XORI  = 6'h0e;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    localparam logic [5:0] OPC_LB    = 6'h20;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_LBU   = 6'h24;
    localparam logic [5:0] OPC_SH    = 6'h29;
    localparam logic [5:0] OPC_SW    = 6'h2b;

    // Funct codes of the R-type group live in instr[5:0].
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        AGU_NONE, AGU_MEM, AGU_BRANCH, AGU_JUMP, AGU_JUMP_REG
    } agu_op_t;

    typedef enum logic [1:0] {DST_NONE, DST_RD, DST_RT, DST_RA} alu_dst_t;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_t;

endpackage

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // Control and operand bundle held in the ID/EX register.
    typedef struct packed {
        logic                        valid;
        logic [isa_pkg::NBITS-1:0]   pc;
        logic [4:0]                  rd;
        logic [4:0]                  rt;
        logic [25:0]                 addr_offset;
        logic                        flg_equal;
        logic                        flg_mem_op;
        logic                        flg_mem_type;
        isa_pkg::mem_size_t          flg_mem_size;
        logic                        flg_unsign;
        logic                        alu_enable;
        isa_pkg::alu_dst_t           alu_dst;
        isa_pkg::alu_op_t            alu_opcode;
        logic                        agu_enable;
        logic                        agu_dst;
        isa_pkg::agu_op_t            agu_opcode;
        logic                        flg_branch;
        logic                        flg_jump;
        logic [isa_pkg::NBITS-1:0]   alu_src_a;
        logic [isa_pkg::NBITS-1:0]   alu_src_b;
        logic [isa_pkg::NBITS-1:0]   agu_src_addr;
        logic [isa_pkg::NBITS-1:0]   store_data;
    } id_ex_t;

    // Result bundle handed to the memory stage.
    typedef struct packed {
        logic                        valid;
        logic                        wr_en;
        logic [4:0]                  wr_reg;
        logic [isa_pkg::NBITS-1:0]   alu_result;
        logic [isa_pkg::NBITS-1:0]   mem_addr;
        logic [isa_pkg::NBITS-1:0]   store_data;
        logic                        mem_op;
        logic                        mem_type;
        isa_pkg::mem_size_t          mem_size;
        logic                        mem_unsign;
    } ex_mem_t;

endpackage

`default_nettype wire

// File: verilog/instr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decode (
    input  wire logic                      i_valid,
    input  wire logic [31:0]               i_instr,
    input  wire logic [isa_pkg::NBITS-1:0] i_pc,
    input  wire logic [isa_pkg::NBITS-1:0] i_rs_data,
    input  wire logic [isa_pkg::NBITS-1:0] i_rt_data,
    output pipe_pkg::id_ex_t               o_id_ex
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic [NBITS-1:0] shamt_ext;
    logic [NBITS-1:0] imm_sext;
    logic [NBITS-1:0] imm_zext;
    logic             known;

    assign opcode    = i_instr[31:26];
    assign funct     = i_instr[5:0];
    assign shamt_ext = {{(NBITS-5){1'b0}}, i_instr[10:6]};
    assign imm_sext  = {{(NBITS-16){i_instr[15]}}, i_instr[15:0]};
    assign imm_zext  = {{(NBITS-16){1'b0}}, i_instr[15:0]};

    always_comb begin
        o_id_ex              = '0;
        known                = 1'b1;
        o_id_ex.pc           = i_pc;
        o_id_ex.rd           = i_instr[15:11];
        o_id_ex.rt           = i_instr[20:16];
        o_id_ex.addr_offset  = i_instr[25:0];
        o_id_ex.alu_src_a    = i_rs_data;
        o_id_ex.alu_src_b    = i_rt_data;
        o_id_ex.agu_src_addr = i_rs_data;
        o_id_ex.store_data   = i_rt_data;

        case (opcode)
            OPC_RTYPE: begin
                o_id_ex.alu_enable = 1'b1;
                o_id_ex.alu_dst    = DST_RD;
                case (funct)
                    FN_SLL:  o_id_ex.alu_opcode = ALU_SLL;
                    FN_SRL:  o_id_ex.alu_opcode = ALU_SRL;
                    FN_SRA:  o_id_ex.alu_opcode = ALU_SRA;
                    FN_ADDU: o_id_ex.alu_opcode = ALU_ADD;
                    FN_SUBU: o_id_ex.alu_opcode = ALU_SUB;
                    FN_AND:  o_id_ex.alu_opcode = ALU_AND;
                    FN_OR:   o_id_ex.alu_opcode = ALU_OR;
                    FN_XOR:  o_id_ex.alu_opcode = ALU_XOR;
                    FN_NOR:  o_id_ex.alu_opcode = ALU_NOR;
                    FN_SLT:  o_id_ex.alu_opcode = ALU_SLT;
                    FN_SLTU: o_id_ex.alu_opcode = ALU_SLTU;
                    FN_JR: begin
                        o_id_ex.alu_enable = 1'b0;
                        o_id_ex.alu_dst    = DST_NONE;
                        o_id_ex.agu_enable = 1'b1;
                        o_id_ex.agu_dst    = 1'b1;
                        o_id_ex.agu_opcode = AGU_JUMP_REG;
                        o_id_ex.flg_jump   = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
                // Shifts take the amount from the shamt field, not from rs.
                if (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA) begin
                    o_id_ex.alu_src_a = shamt_ext;
                end
            end
            OPC_J, OPC_JAL: begin
                o_id_ex.agu_enable = 1'b1;
                o_id_ex.agu_dst    = 1'b1;
                o_id_ex.agu_opcode = AGU_JUMP;
                o_id_ex.flg_jump   = 1'b1;
                if (opcode == OPC_JAL) begin
                    // The link value pc + 4 is formed by the ALU.
                    o_id_ex.alu_enable = 1'b1;
                    o_id_ex.alu_dst    = DST_RA;
                    o_id_ex.alu_opcode = ALU_ADD;
                    o_id_ex.alu_src_a  = i_pc;
                    o_id_ex.alu_src_b  = {{(NBITS-3){1'b0}}, 3'd4};
                end
            end
            OPC_BEQ, OPC_BNE: begin
                o_id_ex.agu_enable = 1'b1;
                o_id_ex.agu_dst    = 1'b1;
                o_id_ex.agu_opcode = AGU_BRANCH;
                o_id_ex.flg_branch = 1'b1;
                o_id_ex.flg_equal  = (opcode == OPC_BEQ);
            end
            OPC_ADDIU, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
                o_id_ex.alu_enable = 1'b1;
                o_id_ex.alu_dst    = DST_RT;
                o_id_ex.alu_src_b  = imm_sext;
                case (opcode)
                    OPC_ADDIU: o_id_ex.alu_opcode = ALU_ADD;
                    OPC_SLTI:  o_id_ex.alu_opcode = ALU_SLT;
                    OPC_ANDI:  o_id_ex.alu_opcode = ALU_AND;
                    OPC_ORI:   o_id_ex.alu_opcode = ALU_OR;
                    OPC_XORI:  o_id_ex.alu_opcode = ALU_XOR;
                    default:   o_id_ex.alu_opcode = ALU_LUI;
                endcase
                if (opcode != OPC_ADDIU && opcode != OPC_SLTI) begin
                    o_id_ex.alu_src_b = imm_zext;
                end
            end
            OPC_LB, OPC_LBU, OPC_LW: begin
                o_id_ex.flg_mem_op   = 1'b1;
                o_id_ex.flg_mem_size = (opcode == OPC_LW) ? SIZE_WORD : SIZE_BYTE;
                o_id_ex.flg_unsign   = (opcode == OPC_LBU);
                o_id_ex.agu_enable   = 1'b1;
                o_id_ex.agu_opcode   = AGU_MEM;
                // Loads reserve rt for the value returned by memory.
                o_id_ex.alu_enable   = 1'b1;
                o_id_ex.alu_dst      = DST_RT;
                o_id_ex.alu_opcode   = ALU_ADD;
                o_id_ex.alu_src_b    = imm_sext;
            end
            OPC_SH, OPC_SW: begin
                o_id_ex.flg_mem_op   = 1'b1;
                o_id_ex.flg_mem_type = 1'b1;
                o_id_ex.flg_mem_size = (opcode == OPC_SW) ? SIZE_WORD : SIZE_HALF;
                o_id_ex.agu_enable   = 1'b1;
                o_id_ex.agu_opcode   = AGU_MEM;
            end
            default: known = 1'b0;
        endcase

        o_id_ex.valid = i_valid & known;
    end

endmodule

`default_nettype wire

// File: verilog/pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  wire logic i_clk,
    input  wire logic i_rst,
    input  wire logic i_stall,
    input  wire logic i_flush,
    input  wire T     i_data,
    output T          o_data
);

    // A stall wins over a flush, so a held bundle is never lost.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_data <= '0;
        end else if (!i_stall) begin
            if (i_flush) begin
                o_data <= '0;
            end else begin
                o_data <= i_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire isa_pkg::alu_op_t           i_op,
    input  wire logic [isa_pkg::NBITS-1:0]  i_src_a,
    input  wire logic [isa_pkg::NBITS-1:0]  i_src_b,
    output logic [isa_pkg::NBITS-1:0]       o_result
);

    import isa_pkg::*;

    logic [4:0] shamt;

    // Shift amount comes from the low bits of operand A.
    assign shamt = i_src_a[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_src_a + i_src_b;
            ALU_SUB:  o_result = i_src_a - i_src_b;
            ALU_AND:  o_result = i_src_a & i_src_b;
            ALU_OR:   o_result = i_src_a | i_src_b;
            ALU_XOR:  o_result = i_src_a ^ i_src_b;
            ALU_NOR:  o_result = ~(i_src_a | i_src_b);
            ALU_SLT: begin
                o_result = {{(NBITS-1){1'b0}}, ($signed(i_src_a) < $signed(i_src_b))};
            end
            ALU_SLTU: begin
                o_result = {{(NBITS-1){1'b0}}, (i_src_a < i_src_b)};
            end
            ALU_SLL:  o_result = i_src_b << shamt;
            ALU_SRL:  o_result = i_src_b >> shamt;
            ALU_SRA:  o_result = $signed(i_src_b) >>> shamt;
            ALU_LUI:  o_result = {i_src_b[15:0], 16'h0000};
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/agu.sv
`timescale 1ns/10ps
`default_nettype none

module agu (
    input  wire logic                       i_valid,
    input  wire logic                       i_stall,
    input  wire isa_pkg::agu_op_t           i_op,
    input  wire logic [isa_pkg::NBITS-1:0]  i_pc,
    input  wire logic [25:0]                i_offset,
    input  wire logic                       i_equal,
    input  wire logic [isa_pkg::NBITS-1:0]  i_src_a,
    input  wire logic [isa_pkg::NBITS-1:0]  i_src_b,
    input  wire logic [isa_pkg::NBITS-1:0]  i_src_addr,
    output logic [isa_pkg::NBITS-1:0]       o_mem_addr,
    output logic                            o_redirect,
    output logic [isa_pkg::NBITS-1:0]       o_redirect_pc
);

    import isa_pkg::*;

    logic [NBITS-1:0] off_sext;
    logic [NBITS-1:0] pc_plus4;
    logic [NBITS-1:0] branch_target;
    logic [NBITS-1:0] jump_target;
    logic             taken;

    assign off_sext      = {{(NBITS-16){i_offset[15]}}, i_offset[15:0]};
    assign pc_plus4      = i_pc + {{(NBITS-3){1'b0}}, 3'd4};
    assign branch_target = pc_plus4 + {off_sext[NBITS-3:0], 2'b00};
    // Jumps stay inside the 256 MB region of the next instruction.
    assign jump_target   = {pc_plus4[NBITS-1:NBITS-4], i_offset, 2'b00};

    assign o_mem_addr = i_src_addr + off_sext;

    always_comb begin
        taken         = 1'b0;
        o_redirect_pc = branch_target;
        case (i_op)
            AGU_BRANCH: taken = ((i_src_a == i_src_b) == i_equal);
            AGU_JUMP: begin
                taken         = 1'b1;
                o_redirect_pc = jump_target;
            end
            AGU_JUMP_REG: begin
                taken         = 1'b1;
                o_redirect_pc = i_src_addr;
            end
            default: taken = 1'b0;
        endcase
    end

    // No redirect while stalled; the instruction is still held in ID/EX.
    assign o_redirect = i_valid & ~i_stall & taken;

endmodule

`default_nettype wire

// File: verilog/ex_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module ex_core_top (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst,
    input  wire logic                      i_valid,
    input  wire logic [31:0]               i_instr,
    input  wire logic [isa_pkg::NBITS-1:0] i_pc,
    input  wire logic [isa_pkg::NBITS-1:0] i_rs_data,
    input  wire logic [isa_pkg::NBITS-1:0] i_rt_data,
    input  wire logic                      i_stall,
    output pipe_pkg::ex_mem_t              o_ex_mem,
    output logic                           o_redirect,
    output logic [isa_pkg::NBITS-1:0]      o_redirect_pc
);

    import isa_pkg::*;
    import pipe_pkg::*;

    id_ex_t           id_ex_d;
    id_ex_t           id_ex_q;
    ex_mem_t          ex_mem_d;
    logic [NBITS-1:0] alu_result;
    logic [NBITS-1:0] mem_addr;

    instr_decode u_decode (
        .i_valid   (i_valid),
        .i_instr   (i_instr),
        .i_pc      (i_pc),
        .i_rs_data (i_rs_data),
        .i_rt_data (i_rt_data),
        .o_id_ex   (id_ex_d)
    );

    // A taken redirect squashes the younger instruction entering ID/EX.
    pipe_reg #(.T(id_ex_t)) u_id_ex (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (i_stall),
        .i_flush (o_redirect),
        .i_data  (id_ex_d),
        .o_data  (id_ex_q)
    );

    alu u_alu (
        .i_op     (id_ex_q.alu_opcode),
        .i_src_a  (id_ex_q.alu_src_a),
        .i_src_b  (id_ex_q.alu_src_b),
        .o_result (alu_result)
    );

    agu u_agu (
        .i_valid       (id_ex_q.valid & id_ex_q.agu_enable),
        .i_stall       (i_stall),
        .i_op          (id_ex_q.agu_opcode),
        .i_pc          (id_ex_q.pc),
        .i_offset      (id_ex_q.addr_offset),
        .i_equal       (id_ex_q.flg_equal),
        .i_src_a       (id_ex_q.alu_src_a),
        .i_src_b       (id_ex_q.alu_src_b),
        .i_src_addr    (id_ex_q.agu_src_addr),
        .o_mem_addr    (mem_addr),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    always_comb begin
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.wr_en      = id_ex_q.valid & id_ex_q.alu_enable;
        case (id_ex_q.alu_dst)
            DST_RD:  ex_mem_d.wr_reg = id_ex_q.rd;
            DST_RT:  ex_mem_d.wr_reg = id_ex_q.rt;
            DST_RA:  ex_mem_d.wr_reg = 5'(REG_RA);
            default: ex_mem_d.wr_reg = 5'd0;
        endcase
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.mem_addr   = mem_addr;
        ex_mem_d.store_data = id_ex_q.store_data;
        ex_mem_d.mem_op     = id_ex_q.flg_mem_op;
        ex_mem_d.mem_type   = id_ex_q.flg_mem_type;
        ex_mem_d.mem_size   = id_ex_q.flg_mem_size;
        ex_mem_d.mem_unsign = id_ex_q.flg_unsign;
    end

    pipe_reg #(.T(ex_mem_t)) u_ex_mem (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (i_stall),
        .i_flush (1'b0),
        .i_data  (ex_mem_d),
        .o_data  (o_ex_mem)
    );

endmodule

`default_nettype wire

// File: testbench/tb_ex_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_core;

    import isa_pkg::*;
    import pipe_pkg::*;

    // What one instruction should leave behind in EX/MEM and on the redirect port.
    typedef struct packed {
        logic        valid;
        logic        wr_en;
        logic [4:0]  wr_reg;
        logic        chk_result;
        logic [31:0] alu_result;
        logic        mem_op;
        logic        mem_type;
        mem_size_t   mem_size;
        logic        mem_unsign;
        logic [31:0] mem_addr;
        logic [31:0] store_data;
        logic        taken;
        logic [31:0] target;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        stall;
    ex_mem_t     ex_mem;
    logic        redirect;
    logic [31:0] redirect_pc;

    integer      seed = 32'ha6a6;
    expect_t     m_id;
    expect_t     m_ex;
    logic        exp_redirect;

    logic [31:0] prog_instr[$];
    logic [31:0] prog_rs[$];
    logic [31:0] prog_rt[$];
    int          prog_stall[$];

    ex_core_top dut (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_valid       (valid),
        .i_instr       (instr),
        .i_pc          (pc),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_stall       (stall),
        .o_ex_mem      (ex_mem),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    function automatic int stall_len();
        return 2 + int'(rnd32() % 32'd4);
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh);
        return {OPC_RTYPE, 5'd0, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [15:0] imm);
        return {op, 5'd0, rt, imm};
    endfunction

    function automatic expect_t predict(input logic v, input logic [31:0] ins,
                                        input logic [31:0] pc_in, input logic [31:0] rs,
                                        input logic [31:0] rt);
        expect_t     e;
        logic [5:0]  op;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] pc4;
        e            = '0;
        op           = ins[31:26];
        sx           = {{16{ins[15]}}, ins[15:0]};
        zx           = {16'h0000, ins[15:0]};
        pc4          = pc_in + 32'd4;
        e.valid      = v;
        e.chk_result = 1'b1;
        e.mem_addr   = rs + sx;
        e.store_data = rt;
        case (op)
            OPC_RTYPE: begin
                e.wr_en  = 1'b1;
                e.wr_reg = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: e.alu_result = rs + rt;
                    FN_SUBU: e.alu_result = rs - rt;
                    FN_AND:  e.alu_result = rs & rt;
                    FN_OR:   e.alu_result = rs | rt;
                    FN_XOR:  e.alu_result = rs ^ rt;
                    FN_NOR:  e.alu_result = ~(rs | rt);
                    FN_SLT:  e.alu_result = {31'd0, $signed(rs) < $signed(rt)};
                    FN_SLTU: e.alu_result = {31'd0, rs < rt};
                    FN_SLL:  e.alu_result = rt << ins[10:6];
                    FN_SRL:  e.alu_result = rt >> ins[10:6];
                    FN_SRA:  e.alu_result = $signed(rt) >>> ins[10:6];
                    FN_JR: begin
                        e.wr_en  = 1'b0;
                        e.taken  = 1'b1;
                        e.target = rs;
                    end
                    default: e.valid = 1'b0;
                endcase
            end
            OPC_J, OPC_JAL: begin
                e.taken  = 1'b1;
                e.target = {pc4[31:28], ins[25:0], 2'b00};
                if (op == OPC_JAL) begin
                    e.wr_en      = 1'b1;
                    e.wr_reg     = 5'd31;
                    e.alu_result = pc4;
                end
            end
            OPC_BEQ, OPC_BNE: begin
                e.taken  = ((rs == rt) == (op == OPC_BEQ));
                e.target = pc4 + {sx[29:0], 2'b00};
            end
            OPC_ADDIU, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
                e.wr_en  = 1'b1;
                e.wr_reg = ins[20:16];
                case (op)
                    OPC_ADDIU: e.alu_result = rs + sx;
                    OPC_SLTI:  e.alu_result = {31'd0, $signed(rs) < $signed(sx)};
                    OPC_ANDI:  e.alu_result = rs & zx;
                    OPC_ORI:   e.alu_result = rs | zx;
                    OPC_XORI:  e.alu_result = rs ^ zx;
                    default:   e.alu_result = {ins[15:0], 16'h0000};
                endcase
            end
            OPC_LB, OPC_LBU, OPC_LW: begin
                e.mem_op     = 1'b1;
                e.wr_en      = 1'b1;
                e.wr_reg     = ins[20:16];
                e.chk_result = 1'b0;
                e.mem_unsign = (op == OPC_LBU);
                e.mem_size   = (op == OPC_LW) ? SIZE_WORD : SIZE_BYTE;
            end
            OPC_SH, OPC_SW: begin
                e.mem_op   = 1'b1;
                e.mem_type = 1'b1;
                e.mem_size = (op == OPC_SW) ? SIZE_WORD : SIZE_HALF;
            end
            default: e.valid = 1'b0;
        endcase
        if (!e.valid) begin
            e = '0;
        end
        return e;
    endfunction

    // Reference pipeline that mirrors the ID/EX and EX/MEM registers.
    assign exp_redirect = m_id.valid & m_id.taken & ~stall;

    always @(posedge clk) begin
        if (rst) begin
            m_id <= '0;
            m_ex <= '0;
        end else if (!stall) begin
            m_ex <= m_id;
            if (exp_redirect) begin
                m_id <= '0;
            end else begin
                m_id <= predict(valid, instr, pc, rs_data, rt_data);
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] gotv);
        $display("ERR %s expected=%h actual=%h", name, expv, gotv);
        $display("Simulation failed");
        $fatal(1, "value check on %s", name);
    endtask

    task automatic stop_after(input int cycles);
        #(cycles * 10);
        $display("Timeout: the instruction sequence did not finish in %0d cycles", cycles);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    endtask

    task automatic add_step(input logic [31:0] ins, input logic [31:0] rs,
                            input logic [31:0] rt, input int stall_cycles);
        prog_instr.push_back(ins);
        prog_rs.push_back(rs);
        prog_rt.push_back(rt);
        prog_stall.push_back(stall_cycles);
    endtask

    task automatic add_filler(input int stall_cycles);
        add_step(enc_r(FN_ADDU, 5'(rnd32()), 5'(rnd32()), 5'd0), rnd32(), rnd32(),
                 stall_cycles);
    endtask

    task automatic build_program();
        logic [5:0]  alu_fns [11];
        logic [5:0]  imm_ops [6];
        logic [5:0]  mem_ops [5];
        logic [31:0] v;
        alu_fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
        imm_ops = '{OPC_ADDIU, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI};
        mem_ops = '{OPC_LB, OPC_LBU, OPC_LW, OPC_SH, OPC_SW};
        foreach (alu_fns[k]) begin
            add_step(enc_r(alu_fns[k], 5'(rnd32()), 5'(rnd32()), 5'(rnd32())),
                     rnd32(), rnd32(), 0);
        end
        // Bit 15 of the immediate is set so sign and zero extension differ.
        foreach (imm_ops[k]) begin
            add_step(enc_i(imm_ops[k], 5'(rnd32()), 16'(rnd32()) | 16'h8000),
                     rnd32(), rnd32(), 0);
        end
        foreach (mem_ops[k]) begin
            add_step(enc_i(mem_ops[k], 5'(rnd32()), 16'(rnd32()) | 16'h8000),
                     rnd32(), rnd32(), 0);
        end
        // Each control transfer is followed by a filler that a redirect must squash.
        v = rnd32();
        add_step(enc_i(OPC_BEQ, 5'd0, 16'(rnd32())), v, v, 0);
        add_filler(0);
        add_step(enc_i(OPC_BEQ, 5'd0, 16'(rnd32())), v, ~v, 0);
        add_filler(0);
        add_step(enc_i(OPC_BNE, 5'd0, 16'(rnd32())), v, v, 0);
        add_filler(0);
        add_step(enc_i(OPC_BNE, 5'd0, 16'(rnd32())), v, v ^ 32'h1, 0);
        add_filler(0);
        add_step({OPC_J, 26'(rnd32())}, rnd32(), rnd32(), 0);
        add_filler(0);
        add_step({OPC_JAL, 26'(rnd32())}, rnd32(), rnd32(), 0);
        add_filler(0);
        add_step(enc_r(FN_JR, 5'd0, 5'd0, 5'd0), rnd32() & 32'hffff_fffc, rnd32(), 0);
        add_filler(0);
        // A taken branch waits in ID/EX through a stall before it redirects.
        add_step(enc_i(OPC_BEQ, 5'd0, 16'(rnd32())), v, v, 0);
        add_filler(stall_len());
        add_filler(0);
        add_filler(0);
        // This stall holds a valid bundle in EX/MEM.
        add_filler(stall_len());
        add_filler(0);
        add_step({6'h3f, 26'(rnd32())}, rnd32(), rnd32(), 0);
        add_filler(0);
    endtask

    a_valid: assert property (@(negedge clk) disable iff (rst) ex_mem.valid == m_ex.valid)
        else report_mismatch("o_ex_mem.valid", 32'(m_ex.valid), 32'(ex_mem.valid));
    a_wr_en: assert property (@(negedge clk) disable iff (rst)
            !m_ex.valid || ex_mem.wr_en == m_ex.wr_en)
        else report_mismatch("o_ex_mem.wr_en", 32'(m_ex.wr_en), 32'(ex_mem.wr_en));
    a_wr_reg: assert property (@(negedge clk) disable iff (rst)
            !(m_ex.valid && m_ex.wr_en) || ex_mem.wr_reg == m_ex.wr_reg)
        else report_mismatch("o_ex_mem.wr_reg", 32'(m_ex.wr_reg), 32'(ex_mem.wr_reg));
    a_result: assert property (@(negedge clk) disable iff (rst)
            !(m_ex.valid && m_ex.wr_en && m_ex.chk_result) ||
            ex_mem.alu_result == m_ex.alu_result)
        else report_mismatch("o_ex_mem.alu_result", m_ex.alu_result, ex_mem.alu_result);
    a_mem_op: assert property (@(negedge clk) disable iff (rst)
            !m_ex.valid || ex_mem.mem_op == m_ex.mem_op)
        else report_mismatch("o_ex_mem.mem_op", 32'(m_ex.mem_op), 32'(ex_mem.mem_op));
    a_mem_addr: assert property (@(negedge clk) disable iff (rst)
            !(m_ex.valid && m_ex.mem_op) || ex_mem.mem_addr == m_ex.mem_addr)
        else report_mismatch("o_ex_mem.mem_addr", m_ex.mem_addr, ex_mem.mem_addr);
    a_store_data: assert property (@(negedge clk) disable iff (rst)
            !(m_ex.valid && m_ex.mem_op) || ex_mem.store_data == m_ex.store_data)
        else report_mismatch("o_ex_mem.store_data", m_ex.store_data, ex_mem.store_data);
    a_mem_flags: assert property (@(negedge clk) disable iff (rst)
            !(m_ex.valid && m_ex.mem_op) ||
            {ex_mem.mem_type, ex_mem.mem_size, ex_mem.mem_unsign} ==
            {m_ex.mem_type, m_ex.mem_size, m_ex.mem_unsign})
        else report_mismatch("o_ex_mem.{mem_type,mem_size,mem_unsign}",
                             32'({m_ex.mem_type, m_ex.mem_size, m_ex.mem_unsign}),
                             32'({ex_mem.mem_type, ex_mem.mem_size, ex_mem.mem_unsign}));
    a_redirect: assert property (@(negedge clk) disable iff (rst) redirect == exp_redirect)
        else report_mismatch("o_redirect", 32'(exp_redirect), 32'(redirect));
    a_target: assert property (@(negedge clk) disable iff (rst)
            !exp_redirect || redirect_pc == m_id.target)
        else report_mismatch("o_redirect_pc", m_id.target, redirect_pc);

    initial begin
        int i;
        int budget;
        rst     = 1'b1;
        valid   = 1'b0;
        instr   = '0;
        pc      = '0;
        rs_data = '0;
        rt_data = '0;
        stall   = 1'b0;
        build_program();
        budget = prog_instr.size() + 20;
        foreach (prog_stall[k]) begin
            budget = budget + prog_stall[k];
        end
        fork
            stop_after(budget);
        join_none
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (i = 0; i < prog_instr.size(); i++) begin
            @(posedge clk);
            valid   <= 1'b1;
            instr   <= prog_instr[i];
            pc      <= 32'h0040_0000 + 32'(i * 4);
            rs_data <= prog_rs[i];
            rt_data <= prog_rt[i];
            stall   <= (prog_stall[i] > 0);
            if (prog_stall[i] > 0) begin
                repeat (prog_stall[i]) @(posedge clk);
                stall <= 1'b0;
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        repeat (4) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/instr_decode.sv
verilog/pipe_reg.sv
verilog/alu.sv
verilog/agu.sv
verilog/ex_core_top.sv
testbench/tb_ex_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_ex_core -o tb_ex_core
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status"
    exit $status
fi

./obj_dir/tb_ex_core
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit $status
fi

exit 0
